/* cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_DATA_W      32
`define CPU_NUM_REGS    16
`define CPU_REG_IDX_W   4
`define CPU_OFFSET_W    19
`define CPU_OP_W        5

`define CPU_OP_LD       0
`define CPU_OP_LDI      1
`define CPU_OP_ST       2

`define CPU_RESET_PC    0

// instruction fields
`define CPU_OP_MSB      31
`define CPU_OP_LSB      27
`define CPU_RA_MSB      26
`define CPU_RA_LSB      23
`define CPU_RB_MSB      22
`define CPU_RB_LSB      19
`define CPU_OFF_MSB     18
`define CPU_OFF_LSB     0

`endif

/* cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

    // data word, also used for word addresses
    typedef logic [`CPU_DATA_W-1:0] word_t;

    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

    typedef logic [`CPU_OP_W-1:0] opcode_t;

    // constant field, sign-extended during address generation
    typedef logic [`CPU_OFFSET_W-1:0] offset_t;

    // one pass per instruction
    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_address,
        st_memory,
        st_writeback
    } cpu_state_t;

endpackage

/* control_unit.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module control_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::word_t     instr,
    input  logic               bus_done,
    output logic               bus_req,
    output logic               bus_we,
    output logic               mdr_load_reg,
    output logic               pc_advance,
    output logic               ea_load,
    output logic               mar_sel_pc,
    output logic               wr_en,
    output logic               wr_sel_ea,
    output cpu_pkg::reg_idx_t  ra,
    output cpu_pkg::reg_idx_t  rb,
    output cpu_pkg::offset_t   offset
);

    cpu_pkg::cpu_state_t state;
    cpu_pkg::cpu_state_t state_nxt;
    cpu_pkg::word_t      ir;
    cpu_pkg::opcode_t    opcode;
    logic                req_sent;
    logic                bus_state;
    logic                op_ld;
    logic                op_ldi;
    logic                op_st;

    // field decode
    assign opcode = ir[`CPU_OP_MSB:`CPU_OP_LSB];
    assign ra     = ir[`CPU_RA_MSB:`CPU_RA_LSB];
    assign rb     = ir[`CPU_RB_MSB:`CPU_RB_LSB];
    assign offset = ir[`CPU_OFF_MSB:`CPU_OFF_LSB];

    assign op_ld  = (opcode == cpu_pkg::opcode_t'(`CPU_OP_LD));
    assign op_ldi = (opcode == cpu_pkg::opcode_t'(`CPU_OP_LDI));
    assign op_st  = (opcode == cpu_pkg::opcode_t'(`CPU_OP_ST));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= cpu_pkg::st_fetch;
            ir       <= '0;
            req_sent <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == cpu_pkg::st_fetch && bus_done) begin
                ir <= instr;
            end
            // one request per fetch or memory phase
            if (bus_done) begin
                req_sent <= 1'b0;
            end else if (bus_req) begin
                req_sent <= 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            cpu_pkg::st_fetch: begin
                if (bus_done) begin
                    state_nxt = cpu_pkg::st_decode;
                end
            end
            cpu_pkg::st_decode: begin
                state_nxt = cpu_pkg::st_address;
            end
            cpu_pkg::st_address: begin
                if (op_ld || op_st) begin
                    state_nxt = cpu_pkg::st_memory;
                end else if (op_ldi) begin
                    state_nxt = cpu_pkg::st_writeback;
                end else begin
                    // unknown opcode, nothing to do
                    state_nxt = cpu_pkg::st_fetch;
                end
            end
            cpu_pkg::st_memory: begin
                if (bus_done) begin
                    state_nxt = op_ld ? cpu_pkg::st_writeback : cpu_pkg::st_fetch;
                end
            end
            cpu_pkg::st_writeback: begin
                state_nxt = cpu_pkg::st_fetch;
            end
            default: begin
                state_nxt = cpu_pkg::st_fetch;
            end
        endcase
    end

    assign bus_state    = (state == cpu_pkg::st_fetch) || (state == cpu_pkg::st_memory);
    assign bus_req      = bus_state && !req_sent;
    assign bus_we       = bus_req && (state == cpu_pkg::st_memory) && op_st;
    assign mdr_load_reg = (state == cpu_pkg::st_address) && op_st;
    assign pc_advance   = (state == cpu_pkg::st_fetch) && bus_done;
    assign ea_load      = (state == cpu_pkg::st_decode);

    // mar follows the pc except when it takes ea for a data access
    assign mar_sel_pc   = !((state == cpu_pkg::st_address) && (op_ld || op_st));

    assign wr_en        = (state == cpu_pkg::st_writeback);
    assign wr_sel_ea    = op_ldi;

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_idx_t  ra,
    input  cpu_pkg::reg_idx_t  rb,
    input  logic               wr_en,
    input  logic               wr_sel_ea,
    input  cpu_pkg::word_t     mdr,
    input  cpu_pkg::word_t     ea,
    output cpu_pkg::word_t     ra_data,
    output cpu_pkg::word_t     base_data
);

    cpu_pkg::word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            // ldi writes the address itself, ld writes the loaded word
            regs[ra] <= wr_sel_ea ? ea : mdr;
        end
    end

    assign ra_data = regs[ra];

    // r0 as base reads as zero, gives absolute addressing
    assign base_data = (rb == '0) ? '0 : regs[rb];

endmodule

/* addr_unit.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module addr_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pc_advance,
    input  logic              ea_load,
    input  logic              mar_sel_pc,
    input  cpu_pkg::offset_t  offset,
    input  cpu_pkg::word_t    base_data,
    output cpu_pkg::word_t    ea,
    output cpu_pkg::word_t    mar
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t offset_ext;

    assign offset_ext = {{(`CPU_DATA_W - `CPU_OFFSET_W){offset[`CPU_OFFSET_W-1]}}, offset};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc  <= cpu_pkg::word_t'(`CPU_RESET_PC);
            mar <= '0;
        end else begin
            if (pc_advance) begin
                pc <= pc + cpu_pkg::word_t'(1);
            end
            // reloaded every cycle, wb_adr keeps the address of an open bus cycle
            mar <= mar_sel_pc ? pc : ea;
        end
    end

    // base plus offset
    always_ff @(posedge clk) begin
        if (ea_load) begin
            ea <= base_data + offset_ext;
        end
    end

endmodule

/* wb_master.sv */
`timescale 1ns/1ps

module wb_master (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            bus_req,
    input  logic            bus_we,
    input  logic            mdr_load_reg,
    input  cpu_pkg::word_t  ra_data,
    input  cpu_pkg::word_t  mar,
    input  cpu_pkg::word_t  wb_dat_i,
    input  logic            wb_ack,
    output logic            bus_done,
    output cpu_pkg::word_t  mdr,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output cpu_pkg::word_t  wb_adr,
    output cpu_pkg::word_t  wb_dat_o
);

    logic ack_edge;

    assign ack_edge = wb_cyc && wb_ack;

    // classic cycle, held until the first acked edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_cyc   <= 1'b0;
            wb_we    <= 1'b0;
            bus_done <= 1'b0;
        end else begin
            bus_done <= ack_edge;
            if (ack_edge) begin
                wb_cyc <= 1'b0;
                wb_we  <= 1'b0;
            end else if (bus_req) begin
                wb_cyc <= 1'b1;
                wb_we  <= bus_we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req && !wb_cyc) begin
            wb_adr <= mar;
        end
        if (ack_edge && !wb_we) begin
            mdr <= wb_dat_i;
        end else if (mdr_load_reg) begin
            mdr <= ra_data;
        end
    end

    assign wb_stb = wb_cyc;

    // mdr only changes outside a write cycle
    assign wb_dat_o = mdr;

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic            clk,
    input  logic            rst_n,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output cpu_pkg::word_t  wb_adr,
    output cpu_pkg::word_t  wb_dat_o,
    input  cpu_pkg::word_t  wb_dat_i,
    input  logic            wb_ack
);

    logic               bus_req;
    logic               bus_we;
    logic               bus_done;
    logic               mdr_load_reg;
    logic               pc_advance;
    logic               ea_load;
    logic               mar_sel_pc;
    logic               wr_en;
    logic               wr_sel_ea;
    cpu_pkg::reg_idx_t  ra;
    cpu_pkg::reg_idx_t  rb;
    cpu_pkg::offset_t   offset;
    cpu_pkg::word_t     mdr;
    cpu_pkg::word_t     ea;
    cpu_pkg::word_t     mar;
    cpu_pkg::word_t     ra_data;
    cpu_pkg::word_t     base_data;

    // instruction word arrives through the mdr
    control_unit control_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (mdr),
        .bus_done     (bus_done),
        .bus_req      (bus_req),
        .bus_we       (bus_we),
        .mdr_load_reg (mdr_load_reg),
        .pc_advance   (pc_advance),
        .ea_load      (ea_load),
        .mar_sel_pc   (mar_sel_pc),
        .wr_en        (wr_en),
        .wr_sel_ea    (wr_sel_ea),
        .ra           (ra),
        .rb           (rb),
        .offset       (offset)
    );

    reg_file regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ra        (ra),
        .rb        (rb),
        .wr_en     (wr_en),
        .wr_sel_ea (wr_sel_ea),
        .mdr       (mdr),
        .ea        (ea),
        .ra_data   (ra_data),
        .base_data (base_data)
    );

    addr_unit addr_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_advance (pc_advance),
        .ea_load    (ea_load),
        .mar_sel_pc (mar_sel_pc),
        .offset     (offset),
        .base_data  (base_data),
        .ea         (ea),
        .mar        (mar)
    );

    wb_master bus_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_req      (bus_req),
        .bus_we       (bus_we),
        .mdr_load_reg (mdr_load_reg),
        .ra_data      (ra_data),
        .mar          (mar),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .bus_done     (bus_done),
        .mdr          (mdr),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_o     (wb_dat_o)
    );

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu;

    logic            clk;
    logic            rst_n;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    cpu_pkg::word_t  wb_adr;
    cpu_pkg::word_t  wb_dat_o;
    cpu_pkg::word_t  wb_dat_i;
    logic            wb_ack;

    // one row per program word, expected store filled in for st rows
    string           row_name [$];
    cpu_pkg::word_t  row_instr [$];
    bit              row_is_store [$];
    cpu_pkg::word_t  row_adr [$];
    cpu_pkg::word_t  row_dat [$];

    cpu_pkg::word_t  mem [cpu_pkg::word_t];
    cpu_pkg::word_t  model_regs [`CPU_NUM_REGS];
    cpu_pkg::word_t  store_adr_q [$];
    cpu_pkg::word_t  store_dat_q [$];
    cpu_pkg::word_t  rng_state;
    cpu_pkg::word_t  next_fetch;
    bit              first_seen;
    int              errors;
    int              fetch_errs;
    int              pass_count;
    int              fail_count;
    int              cycles;
    int              cycle_limit;

    cpu_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    always #10 clk = ~clk;

    function automatic cpu_pkg::word_t xorshift32(input cpu_pkg::word_t x);
        cpu_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // constant field read as a two's complement number
    function automatic cpu_pkg::word_t sign_extend(input int off);
        int field;
        field = off & ((1 << `CPU_OFFSET_W) - 1);
        if (field >= (1 << (`CPU_OFFSET_W - 1))) begin
            field = field - (1 << `CPU_OFFSET_W);
        end
        return cpu_pkg::word_t'(field);
    endfunction

    function automatic cpu_pkg::word_t encode(input int op, input int ra, input int rb,
                                              input int off);
        return {op[`CPU_OP_W-1:0], ra[`CPU_REG_IDX_W-1:0], rb[`CPU_REG_IDX_W-1:0],
                off[`CPU_OFFSET_W-1:0]};
    endfunction

    // r0 as base counts as zero
    function automatic cpu_pkg::word_t eff_addr(input int rb, input int off);
        cpu_pkg::word_t base;
        base = (rb == 0) ? '0 : model_regs[rb[`CPU_REG_IDX_W-1:0]];
        return base + sign_extend(off);
    endfunction

    // unwritten words decode as no-ops
    function automatic cpu_pkg::word_t mem_read(input cpu_pkg::word_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {5'h1f, a[26:0] ^ {22'd0, a[31:27]}};
    endfunction

    task automatic add_row(input string name, input cpu_pkg::word_t instr, input bit is_store,
                           input cpu_pkg::word_t adr, input cpu_pkg::word_t dat);
        mem[cpu_pkg::word_t'(row_instr.size())] = instr;
        row_name.push_back(name);
        row_instr.push_back(instr);
        row_is_store.push_back(is_store);
        row_adr.push_back(adr);
        row_dat.push_back(dat);
    endtask

    task automatic add_ldi(input int ra, input int rb, input int off);
        cpu_pkg::word_t ea;
        ea = eff_addr(rb, off);
        add_row("", encode(`CPU_OP_LDI, ra, rb, off), 1'b0, '0, '0);
        model_regs[ra[`CPU_REG_IDX_W-1:0]] = ea;
    endtask

    task automatic add_ld(input int ra, input int rb, input int off);
        cpu_pkg::word_t ea;
        ea = eff_addr(rb, off);
        add_row("", encode(`CPU_OP_LD, ra, rb, off), 1'b0, '0, '0);
        model_regs[ra[`CPU_REG_IDX_W-1:0]] = mem_read(ea);
    endtask

    task automatic add_st(input string name, input int ra, input int rb, input int off);
        add_row(name, encode(`CPU_OP_ST, ra, rb, off), 1'b1, eff_addr(rb, off),
                model_regs[ra[`CPU_REG_IDX_W-1:0]]);
    endtask

    task automatic build_program();
        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        mem[32'h54]  = 32'hcafe_1234;
        mem[32'h1fc] = 32'h8000_00a5;
        add_ldi(4, 0, 'h54);
        add_st("ldi_imm_store", 4, 0, 'h30);
        add_ldi(2, 0, 'h100);
        add_ldi(6, 2, 'h63);
        add_st("ldi_base_pos", 6, 0, 'h31);
        add_ldi(7, 2, -'h20);
        add_st("ldi_base_neg", 7, 0, 'h32);
        add_ld(4, 0, 'h54);
        add_st("ld_abs_store", 4, 0, 'h33);
        add_ldi(3, 0, 'h200);
        // unknown opcode between ldi and st
        add_row("", encode(31, 1, 2, 'h7), 1'b0, '0, '0);
        add_st("st_base_r3", 3, 3, 'h34);
        add_ld(5, 3, -'h4);
        add_st("ld_base_neg", 5, 0, 'h35);
        add_ldi(8, 0, -1);
        add_st("ldi_all_ones", 8, 0, 'h36);
    endtask

    task automatic check_value(input string name, input cpu_pkg::word_t exp,
                               input cpu_pkg::word_t act, output bit ok);
        ok = (act === exp);
        if (!ok) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic complete_access();
        bit ok;
        if (wb_we) begin
            mem[wb_adr] = wb_dat_o;
            store_adr_q.push_back(wb_adr);
            store_dat_q.push_back(wb_dat_o);
        end else begin
            wb_dat_i = mem_read(wb_adr);
            // program sits below 0x30, data words above
            if (wb_adr < 32'h30) begin
                check_value("fetch_order", next_fetch, wb_adr, ok);
                if (!ok) begin
                    fetch_errs++;
                end
                next_fetch = next_fetch + 32'd1;
            end
        end
    endtask

    // wishbone slave with 0 to 3 wait cycles per access
    initial begin : memory_model
        int unsigned wait_left;
        bit          busy;
        bit          ok;
        busy = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #1;
            if (wb_ack) begin
                wb_ack = 1'b0;
                busy = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!busy) begin
                    busy = 1'b1;
                    rng_state = xorshift32(rng_state);
                    wait_left = rng_state % 4;
                    if (!first_seen) begin
                        first_seen = 1'b1;
                        check_value("first_access_adr", '0, wb_adr, ok);
                        if (!ok) begin
                            fetch_errs++;
                        end
                        check_value("first_access_we", '0, cpu_pkg::word_t'(wb_we), ok);
                        if (!ok) begin
                            fetch_errs++;
                        end
                    end
                end
                if (wait_left == 0) begin
                    complete_access();
                    wb_ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, stores did not all arrive", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        bit             ok_adr;
        bit             ok_dat;
        cpu_pkg::word_t act_adr;
        cpu_pkg::word_t act_dat;
        clk = 1'b0;
        rst_n = 1'b0;
        wb_ack = 1'b0;
        wb_dat_i = '0;
        rng_state = 32'd41515;
        next_fetch = '0;
        first_seen = 1'b0;
        errors = 0;
        fetch_errs = 0;
        pass_count = 0;
        fail_count = 0;
        cycles = 0;
        build_program();
        cycle_limit = row_instr.size() * 20 + 100;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < row_instr.size(); i++) begin
            if (row_is_store[i]) begin
                while (store_adr_q.size() == 0) begin
                    @(posedge clk);
                end
                act_adr = store_adr_q.pop_front();
                act_dat = store_dat_q.pop_front();
                check_value({row_name[i], "_adr"}, row_adr[i], act_adr, ok_adr);
                check_value({row_name[i], "_dat"}, row_dat[i], act_dat, ok_dat);
                if (ok_adr && ok_dat) begin
                    pass_count++;
                    $display("passed %s adr=%h dat=%h", row_name[i], act_adr, act_dat);
                end else begin
                    fail_count++;
                end
            end
        end
        if (fetch_errs == 0) begin
            pass_count++;
            $display("passed fetch_order up to adr=%h", next_fetch);
        end else begin
            fail_count++;
        end
        check_value("extra_writes", '0, cpu_pkg::word_t'(store_adr_q.size()), ok_adr);
        if (ok_adr) begin
            pass_count++;
            $display("passed extra_writes");
        end else begin
            fail_count++;
        end
        $display("tests: %0d passed, %0d failed, %0d mismatches", pass_count, fail_count,
                 errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
cpu_pkg.sv
control_unit.sv
reg_file.sv
addr_unit.sv
wb_master.sv
cpu_top.sv
tb_cpu.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --top-module tb_cpu -f verilog.f -o tb_cpu_sim
./obj_dir/tb_cpu_sim > sim.log
cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi
